/* dv/dac_cases.txt */
// adc_a adc_b level_a level_b ctrl dac_a dac_b   (raw hex words)
// ctrl bit 0 loop_a, bit 1 loop_b; levels are 14-bit two's complement
// all zero
7FFC 7FFC 0000 0000 0000 1FFF 1FFF
// levels only, +100 and -100
7FFC 7FFC 0064 3F9C 0000 1F9B 2063
// loopback only, adc +100 and -100
7E6C 818C 0000 0000 0003 1F9B 2063
// positive and negative saturation
02FC FCFC 03E8 3C18 0003 0000 3FFF
// loop a only
02FC FCFC 0000 0000 0001 00BF 1FFF
// loop b only
02FC FCFC 0000 0000 0002 1FFF 3F3F
// full scale adc, no level
0000 FFFC 0000 0000 0003 0000 3FFF
// one step past full scale clamps
0000 FFFC 0001 3FFF 0003 0000 3FFF
// opposite signs, no clamp
0000 FFFC 2000 1FFF 0003 2000 2000
// unused low adc bits ignored
7FFF 0003 0000 0000 0003 1FFF 0000
// loop off, extreme levels
1234 5678 1FFF 2000 0000 0000 3FFF
// small values around zero
8000 7FF8 0000 0002 0003 2000 1FFC

/* compile.f */
rtl/board_pkg.sv
rtl/analog_io.sv
rtl/dac_mixer.sv
rtl/ctrl_regs.sv
rtl/sys_bus_decoder.sv
rtl/board_top.sv
dv/board_assert.sv
dv/board_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module board_tb \
  -f compile.f -o board_sim
./obj_dir/board_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  exit 1
fi
exit 0

/* dv/board_tb.sv */
/*
 * board testbench
 * bus register access, region decode, directed mixing cases from a
 * file and a random loopback stream through the full adc to dac path
 */
module board_tb
  import board_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_CASES     = 12;
  localparam int N_COLS      = 7;                   // words per case line
  localparam int N_RAND      = 32;
  localparam int CYCLE_LIMIT = 4 * (N_CASES + N_RAND) + 200;

  logic                 adc_clk;
  logic                 rst_i;
  logic [ADC_RAW_W-1:0] adc_a;
  logic [ADC_RAW_W-1:0] adc_b;
  bus_req_t             bus_req;
  bus_rsp_t             bus_rsp;
  logic [SMP_W-1:0]     dac_a;
  logic [SMP_W-1:0]     dac_b;
  logic [7:0]           led;

  logic [15:0] case_mem [0:N_CASES*N_COLS-1];       // directed cases
  int          val_errs;                            // wrong values
  int          other_errs;                          // protocol trouble
  int          cycles;

  board_top DUT (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  bind board_top board_bus_assert u_bus_assert (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .req_i   (bus_req_i),
    .rsp_i   (bus_rsp_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;               // 40 ns period
  end

  // run limit
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////
  // raw adc word to two's complement over the top 14 bits
  // code 0x1fff means zero and the slope is negative
  function automatic sample_t raw_to_sample(input logic [ADC_RAW_W-1:0] raw);
    logic [SMP_W-1:0] r;
    r = raw[ADC_RAW_W-1:ADC_RAW_W-SMP_W];
    return sample_t'(14'h1FFF - r);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [BUS_W-1:0] exp,
                            input logic [BUS_W-1:0] act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s exp=%h/%b/%b act=%h/%b/%b", $time, name,
               exp.rdata, exp.ack, exp.err, act.rdata, act.ack, act.err);
      val_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one request pulse then wait for ack
  //////////////////////////////////////////////////////////////////////
  task automatic bus_access(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
                            input logic wr, output bus_rsp_t rsp);
    int waited;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wen   = wr;
    bus_req.ren   = ~wr;
    @(negedge adc_clk);
    bus_req.wen = 1'b0;                             // one-cycle pulse
    bus_req.ren = 1'b0;
    waited = 0;
    while (!bus_rsp.ack && waited < 4)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!bus_rsp.ack)
    begin
      $display("no ack for the request to address %h", addr);
      other_errs++;
    end
    rsp = bus_rsp;
    @(negedge adc_clk);                             // idle cycle after ack
  endtask

  task automatic bus_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
                           output bus_rsp_t rsp);
    bus_access(addr, wdata, 1'b1, rsp);
  endtask

  task automatic bus_read(input logic [BUS_W-1:0] addr, output bus_rsp_t rsp);
    bus_access(addr, '0, 1'b0, rsp);
  endtask

  // sign extended level word
  function automatic logic [BUS_W-1:0] level_word(input logic [15:0] lvl);
    return {{(BUS_W-SMP_W){lvl[SMP_W-1]}}, lvl[SMP_W-1:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    bus_rsp_t             rsp;
    bus_rsp_t             exp;
    int                   base;
    logic [ADC_RAW_W-1:0] ra [$];                  // raw words in flight
    logic [ADC_RAW_W-1:0] rb [$];
    logic [ADC_RAW_W-1:0] oa;
    logic [ADC_RAW_W-1:0] ob;
    val_errs   = 0;
    other_errs = 0;
    void'($urandom(32'h7bdb));
    $readmemh("dv/dac_cases.txt", case_mem);
    rst_i   = 1'b1;
    adc_a   = '0;
    adc_b   = '0;
    bus_req = '0;
    repeat (2) @(negedge adc_clk);
    rst_i = 1'b0;
    @(negedge adc_clk);

    // reset state
    exp = '0;
    check_rsp("bus_rsp_o", exp, bus_rsp);
    check_word("led_o", 32'h0, {24'h0, led});
    check_sample("dac_dat_a_o", sample_t'(14'h1FFF), dac_a);
    check_sample("dac_dat_b_o", sample_t'(14'h1FFF), dac_b);

    // register write and readback
    exp.ack = 1'b1;
    bus_write(32'(OFS_CTRL), 32'h3, rsp);
    check_rsp("write rsp", exp, rsp);
    bus_read(32'(OFS_CTRL), rsp);
    check_word("ctrl rdata", 32'h3, rsp.rdata);
    bus_write(32'(OFS_LEVEL_A), 32'hFFFF_F000, rsp);
    bus_read(32'(OFS_LEVEL_A), rsp);
    check_word("level_a rdata", 32'hFFFF_F000, rsp.rdata);
    bus_write(32'(OFS_LEVEL_B), 32'h0000_0ABC, rsp);
    bus_read(32'(OFS_LEVEL_B), rsp);
    check_word("level_b rdata", 32'h0000_0ABC, rsp.rdata);
    bus_write(32'(OFS_LED), 32'hA5, rsp);
    bus_read(32'(OFS_LED), rsp);
    check_word("led rdata", 32'hA5, rsp.rdata);
    check_word("led_o", 32'hA5, {24'h0, led});
    bus_read(32'(OFS_ID), rsp);
    check_word("id rdata", BOARD_ID, rsp.rdata);

    // empty regions ack with zero rdata
    for (int r = 1; r < N_REGION; r++)
    begin
      bus_read(32'(r) << REGION_LSB, rsp);
      check_rsp("empty region read", exp, rsp);
      bus_write((32'(r) << REGION_LSB) | 32'h4, 32'hDEAD_BEEF, rsp);
      check_rsp("empty region write", exp, rsp);
    end
    // writes to other regions leave level_a alone
    bus_read(32'(OFS_LEVEL_A), rsp);
    check_word("level_a rdata", 32'hFFFF_F000, rsp.rdata);

    // unknown offset in region 0 errs
    exp.err = 1'b1;
    bus_read(32'h18, rsp);
    check_rsp("unknown offset", exp, rsp);

    // directed mixing cases
    for (int c = 0; c < N_CASES; c++)
    begin
      base = c * N_COLS;
      bus_write(32'(OFS_LEVEL_A), level_word(case_mem[base+2]), rsp);
      bus_write(32'(OFS_LEVEL_B), level_word(case_mem[base+3]), rsp);
      bus_write(32'(OFS_CTRL), {30'h0, case_mem[base+4][1:0]}, rsp);
      adc_a = case_mem[base];
      adc_b = case_mem[base+1];
      repeat (3) @(negedge adc_clk);             // pins to pins
      check_sample("dac_dat_a_o", sample_t'(case_mem[base+5][SMP_W-1:0]), dac_a);
      check_sample("dac_dat_b_o", sample_t'(case_mem[base+6][SMP_W-1:0]), dac_b);
    end

    // random loopback stream with one pair per cycle
    bus_write(32'(OFS_LEVEL_A), 32'h0, rsp);
    bus_write(32'(OFS_LEVEL_B), 32'h0, rsp);
    bus_write(32'(OFS_CTRL), 32'h3, rsp);
    repeat (2) @(negedge adc_clk);               // cfg settles into the mixer
    for (int i = 0; i < N_RAND + 3; i++)
    begin
      if (i >= 3)
      begin
        oa = ra.pop_front();
        ob = rb.pop_front();
        // double conversion cancels so the dac shows the raw top bits
        check_sample("dac_dat_a_o", sample_t'(oa[ADC_RAW_W-1:2]), dac_a);
        check_sample("dac_dat_b_o", sample_t'(ob[ADC_RAW_W-1:2]), dac_b);
      end
      if (i < N_RAND)
      begin
        adc_a = 16'($urandom());
        adc_b = 16'($urandom());
        ra.push_back(adc_a);
        rb.push_back(adc_b);
      end
      @(negedge adc_clk);
    end

    // last pair still held on the pins
    bus_read(32'(OFS_ADC), rsp);
    check_word("adc rdata", {2'b00, raw_to_sample(adc_b), 2'b00, raw_to_sample(adc_a)},
               rsp.rdata);

    $display("errors: %0d value, %0d other", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* dv/board_assert.sv */
/*
 * bus protocol and reset assertions, bound to the board top level
 */
module board_bus_assert
  import board_pkg::*;
(
  input logic     adc_clk,
  input logic     rst_i,
  input bus_req_t req_i,
  input bus_rsp_t rsp_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic req_any;

  assign req_any = req_i.wen | req_i.ren;

  //////////////////////////////////////////////////////////////////////
  // request and acknowledge
  //////////////////////////////////////////////////////////////////////
  ack_follows_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    rsp_i.ack |-> $past(req_any))
    else $error("ack without a request in the previous cycle");

  err_needs_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(rsp_i.err && !rsp_i.ack))
    else $error("err high without ack");

  // first cycle out of reset
  quiet_after_reset: assert property (@(posedge adc_clk)
    $fell(rst_i) |-> (!rsp_i.ack && !rsp_i.err))
    else $error("ack or err high right after reset");

  no_req_while_pending: assert property (@(posedge adc_clk) disable iff (rst_i)
    req_any |=> !req_any)
    else $error("request issued while an ack was pending");

endmodule

/* rtl/board_top.sv */
/*
 * board top level
 * bus fabric and two-channel adc to dac signal path, one clock domain
 */
module board_top
  import board_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_i,
  // adc
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  // system bus
  input  bus_req_t             bus_req_i,
  output bus_rsp_t             bus_rsp_o,
  // dac
  output logic [SMP_W-1:0]     dac_dat_a_o,
  output logic [SMP_W-1:0]     dac_dat_b_o,
  output logic [7:0]           led_o
);

  bus_req_t     ctrl_req;       // region 0 request
  bus_rsp_t     ctrl_rsp;
  sample_pair_t adc_pair;       // converted adc samples
  sample_pair_t mix_pair;       // saturated dac samples
  mix_cfg_t     mix_cfg;

  //////////////////////////////////////////////////////////////////////
  // bus fabric
  //////////////////////////////////////////////////////////////////////
  sys_bus_decoder u_decoder (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .req_i      (bus_req_i),
    .rsp_o      (bus_rsp_o),
    .ctrl_req_o (ctrl_req),
    .ctrl_rsp_i (ctrl_rsp)
  );

  ctrl_regs u_ctrl (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .req_i   (ctrl_req),
    .rsp_o   (ctrl_rsp),
    .adc_i   (adc_pair),        // readback of the latest pair
    .cfg_o   (mix_cfg),
    .led_o   (led_o)
  );

  //////////////////////////////////////////////////////////////////////
  // signal path, pins to pins in 3 cycles
  //////////////////////////////////////////////////////////////////////
  analog_io u_analog (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_o       (adc_pair),
    .mix_i       (mix_pair),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  dac_mixer u_mixer (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .adc_i   (adc_pair),
    .cfg_i   (mix_cfg),
    .mix_o   (mix_pair)
  );

endmodule

/* rtl/sys_bus_decoder.sv */
/*
 * system bus decoder
 * splits the bus into 8 regions, routes region 0 to ctrl_regs,
 * acks the unused regions itself
 */
module sys_bus_decoder
  import board_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_i,
  // master side
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  // ctrl_regs side
  output bus_req_t ctrl_req_o,
  input  bus_rsp_t ctrl_rsp_i
);

  logic [REGION_W-1:0] region;
  logic                to_ctrl;     // request targets ctrl_regs
  logic                req_any;
  logic                sel_ctrl_q;  // region of the last request
  logic                own_ack_q;   // ack for regions without a slave

  assign region  = req_i.addr[REGION_LSB +: REGION_W];
  assign to_ctrl = (region == REGION_W'(REGION_CTRL));
  assign req_any = req_i.wen | req_i.ren;

  // addr and wdata pass through, enables only for region 0
  always_comb
  begin
    ctrl_req_o     = req_i;
    ctrl_req_o.wen = req_i.wen & to_ctrl;
    ctrl_req_o.ren = req_i.ren & to_ctrl;
  end

  //////////////////////////////////////////////////////////////////////
  // remember the region, answer the empty ones
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      sel_ctrl_q <= 1'b0;
      own_ack_q  <= 1'b0;
    end
    else
    begin
      if (req_any)
        sel_ctrl_q <= to_ctrl;
      own_ack_q <= req_any & ~to_ctrl;   // one-cycle pulse
    end
  end

  // response mux
  always_comb
  begin
    if (sel_ctrl_q)
      rsp_o = ctrl_rsp_i;
    else
    begin
      rsp_o.rdata = '0;
      rsp_o.ack   = own_ack_q;
      rsp_o.err   = 1'b0;         // empty regions never fail
    end
  end

endmodule

/* rtl/ctrl_regs.sv */
/*
 * control registers, bus region 0
 * loop enables, dac levels, leds, id word and adc readback
 */
module ctrl_regs
  import board_pkg::*;
(
  input  logic         adc_clk,
  input  logic         rst_i,
  input  bus_req_t     req_i,       // enables already masked to region 0
  output bus_rsp_t     rsp_o,       // registered response
  input  sample_pair_t adc_i,       // latest adc pair
  output mix_cfg_t     cfg_o,
  output logic [7:0]   led_o
);

  logic [REGION_LSB-1:0] ofs;       // offset inside the region
  logic                  ofs_hit;   // listed offset
  logic [BUS_W-1:0]      rd_word;
  mix_cfg_t              cfg_q;
  logic [7:0]            led_q;

  assign ofs = req_i.addr[REGION_LSB-1:0];

  //////////////////////////////////////////////////////////////////////
  // read mux and offset check
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    ofs_hit = 1'b1;
    rd_word = '0;
    case (ofs)
      OFS_CTRL:    rd_word = {{(BUS_W-2){1'b0}}, cfg_q.loop_b, cfg_q.loop_a};
      OFS_LEVEL_A: rd_word = {{(BUS_W-SMP_W){cfg_q.level_a[SMP_W-1]}}, cfg_q.level_a};
      OFS_LEVEL_B: rd_word = {{(BUS_W-SMP_W){cfg_q.level_b[SMP_W-1]}}, cfg_q.level_b};
      OFS_LED:     rd_word = {{(BUS_W-8){1'b0}}, led_q};
      OFS_ID:      rd_word = BOARD_ID;
      OFS_ADC:     rd_word = {2'b00, adc_i.b, 2'b00, adc_i.a};   // pair as seen now
      default:     ofs_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // register writes and response
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cfg_q <= '0;
      led_q <= '0;
      rsp_o <= '0;
    end
    else
    begin
      if (req_i.wen)
      begin
        case (ofs)
          OFS_CTRL:
          begin
            cfg_q.loop_a <= req_i.wdata[0];
            cfg_q.loop_b <= req_i.wdata[1];
          end
          OFS_LEVEL_A: cfg_q.level_a <= req_i.wdata[SMP_W-1:0];
          OFS_LEVEL_B: cfg_q.level_b <= req_i.wdata[SMP_W-1:0];
          OFS_LED:     led_q <= req_i.wdata[7:0];
          default:     ;                  // id and adc are read only
        endcase
      end
      // exactly one ack per request, next cycle
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~ofs_hit;
      rsp_o.rdata <= req_i.ren ? rd_word : '0;
    end
  end

  assign cfg_o = cfg_q;
  assign led_o = led_q;

endmodule

/* rtl/dac_mixer.sv */
/*
 * dac mixer
 * per channel: level plus optional adc loopback, saturated to 14 bits
 */
module dac_mixer
  import board_pkg::*;
(
  input  logic         adc_clk,
  input  logic         rst_i,
  input  sample_pair_t adc_i,     // converted adc pair
  input  mix_cfg_t     cfg_i,     // loop enables and levels
  output sample_pair_t mix_o      // registered, 1 cycle
);

  // one channel of the mix
  // 15-bit sum, clamped to -8192..8191
  function automatic sample_t mix_ch(
    input sample_t level,
    input sample_t smp,
    input logic    loop_en
  );
    logic [SMP_W:0] addend;
    logic [SMP_W:0] sum;
    addend = loop_en ? {smp[SMP_W-1], smp} : '0;   // zero when loop is off
    sum    = {level[SMP_W-1], level} + addend;
    // top two bits differ -> overflow, clamp toward the sign
    if (sum[SMP_W] != sum[SMP_W-1])
      return {sum[SMP_W], {(SMP_W-1){~sum[SMP_W]}}};
    return sum[SMP_W-1:0];
  endfunction

  sample_pair_t mix_d;
  sample_pair_t mix_q;

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    mix_d.a = mix_ch(cfg_i.level_a, adc_i.a, cfg_i.loop_a);
    mix_d.b = mix_ch(cfg_i.level_b, adc_i.b, cfg_i.loop_b);
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      mix_q <= '0;              // mid scale on the dac
    else
      mix_q <= mix_d;
  end

  assign mix_o = mix_q;

endmodule

/* rtl/analog_io.sv */
/*
 * analog io
 * adc capture into two's complement, dac output register back
 * into negative-slope offset binary
 */
module analog_io
  import board_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_i,
  // adc side
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,   // ch a raw word
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,   // ch b raw word
  output sample_pair_t         adc_o,         // converted pair
  // dac side
  input  sample_pair_t         mix_i,         // mixed pair, signed
  output logic [SMP_W-1:0]     dac_dat_a_o,
  output logic [SMP_W-1:0]     dac_dat_b_o
);

  // same rule both ways: sign bit kept, lower bits inverted
  function automatic logic [SMP_W-1:0] flip_ob(input logic [SMP_W-1:0] v);
    return {v[SMP_W-1], ~v[SMP_W-2:0]};
  endfunction

  sample_pair_t     adc_q;                    // io register, converted
  logic [SMP_W-1:0] dac_a_q;
  logic [SMP_W-1:0] dac_b_q;

  //////////////////////////////////////////////////////////////////////
  // adc capture, 1 cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      adc_q <= '0;
    else
    begin
      // top 14 bits only
      adc_q.a <= flip_ob(adc_dat_a_i[ADC_RAW_W-1 -: SMP_W]);
      adc_q.b <= flip_ob(adc_dat_b_i[ADC_RAW_W-1 -: SMP_W]);
    end
  end

  assign adc_o = adc_q;

  //////////////////////////////////////////////////////////////////////
  // dac output register, 1 cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_a_q <= {1'b0, {(SMP_W-1){1'b1}}};   // 0x1fff, code for zero
      dac_b_q <= {1'b0, {(SMP_W-1){1'b1}}};
    end
    else
    begin
      dac_a_q <= flip_ob(mix_i.a);
      dac_b_q <= flip_ob(mix_i.b);
    end
  end

  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;

endmodule

/* rtl/board_pkg.sv */
/*
 * board package
 * widths, system bus map and packed types shared by the board top level
 */
package board_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////
  localparam int SMP_W     = 14;                // converter sample
  localparam int ADC_RAW_W = 16;                // adc port, 2 lsbs unused
  localparam int BUS_W     = 32;                // bus addr and data

  // bus regions
  localparam int N_REGION    = 8;
  localparam int REGION_W    = $clog2(N_REGION); // 3-bit region field
  localparam int REGION_LSB  = 20;
  localparam int REGION_CTRL = 0;               // ctrl_regs lives here

  // ctrl_regs offsets, low addr bits below the region field
  localparam logic [REGION_LSB-1:0] OFS_CTRL    = 'h00; // [0] loop_a, [1] loop_b
  localparam logic [REGION_LSB-1:0] OFS_LEVEL_A = 'h04; // signed, 14 lsbs
  localparam logic [REGION_LSB-1:0] OFS_LEVEL_B = 'h08;
  localparam logic [REGION_LSB-1:0] OFS_LED     = 'h0C; // 8 bits
  localparam logic [REGION_LSB-1:0] OFS_ID      = 'h10; // read only
  localparam logic [REGION_LSB-1:0] OFS_ADC     = 'h14; // a in 13..0, b in 29..16

  localparam logic [BUS_W-1:0] BOARD_ID = 32'hAD0C_0102;

  //////////////////////////////////////////////////////////////////////
  // packed types
  //////////////////////////////////////////////////////////////////////
  typedef logic signed [SMP_W-1:0] sample_t;    // two's complement

  typedef struct packed {
    sample_t a;
    sample_t b;
  } sample_pair_t;

  typedef struct packed {
    logic    loop_a;                            // add adc a to level a
    logic    loop_b;
    sample_t level_a;
    sample_t level_b;
  } mix_cfg_t;

  typedef struct packed {
    logic [BUS_W-1:0] addr;
    logic [BUS_W-1:0] wdata;                    // always full word
    logic             wen;                      // one-cycle pulse
    logic             ren;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;
    logic             ack;                      // cycle after the request
    logic             err;                      // only together with ack
  } bus_rsp_t;

endpackage
